/* Makefile */
# Verilator build and run of the rv_id_ex testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_id_ex
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard include/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q '^TEST OK$$' $(LOG) && echo "PASS" || (echo "FAIL, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
+incdir+include
src/rv_pkg.sv
src/rv_decode_ctrl.sv
src/rv_regfile.sv
src/rv_imm_gen.sv
src/rv_alu_stage.sv
src/rv_id_ex.sv
dv/tb_clkgen.sv
dv/rv_id_ex_sva.sv
dv/tb_rv_id_ex.sv

/* dv/rv_id_ex_sva.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_id_ex_sva
    import rv_pkg::*;
(
    input logic     clk,
    input logic     rst_n,
    input logic     instr_valid,
    input logic     result_valid,
    input reg_sel_t rd,
    input logic     write_reg,
    input logic     mem_read,
    input logic     mem_write,
    input logic     branch,
    input logic     branch_taken,
    input logic     illegal
);

    int unsigned fail_count = 0;    // Read by the testbench at end of run

    ////////////////////////////////////////////////////////////
    // Result strobe, exactly one cycle after issue
    ////////////////////////////////////////////////////////////
    valid_after_issue: assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid |=> result_valid)
        else begin
            $error("result_valid low one cycle after instr_valid");
            fail_count++;
        end

    no_valid_after_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !instr_valid |=> !result_valid)
        else begin
            $error("result_valid high one cycle after an idle cycle");
            fail_count++;
        end

    // Load and store flags are exclusive
    mem_flags_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_read && mem_write))
        else begin
            $error("mem_read and mem_write both high");
            fail_count++;
        end

    write_not_x0: assert property (@(posedge clk) disable iff (!rst_n)
        write_reg |-> (rd != '0))   // x0 never written
        else begin
            $error("write_reg high with rd equal to x0");
            fail_count++;
        end

    // Everything quiet while reset is held
    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> !(result_valid || write_reg || mem_read || mem_write ||
                     branch || branch_taken || illegal))
        else begin
            $error("Output flag high during reset");
            fail_count++;
        end

endmodule

bind rv_id_ex rv_id_ex_sva i_rv_id_ex_sva (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_valid  (instr_valid),
    .result_valid (result_valid),
    .rd           (rd),
    .write_reg    (write_reg),
    .mem_read     (mem_read),
    .mem_write    (mem_write),
    .branch       (branch),
    .branch_taken (branch_taken),
    .illegal      (illegal)
);

`default_nettype wire

/* dv/tb_clkgen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD_NS = 20;    // 40 ns clock
    localparam int RESET_CYCLES   = 8;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD_NS clk = ~clk;
    end

    // Release away from the rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* dv/tb_rv_id_ex.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_rv_id_ex
    import rv_pkg::*;
();

    localparam int unsigned NUM_INSTR      = 2000;
    localparam int unsigned TIMEOUT_CYCLES = NUM_INSTR * 13 / 10 + 100;
    localparam int unsigned RAND_SEED      = 32'h515b_a271;

    // RV32I opcodes, straight from the ISA tables
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    logic     clk;
    logic     rst_n;
    word_t    instr;
    logic     instr_valid;
    word_t    result;
    logic     result_valid;
    reg_sel_t rd;
    logic     write_reg;
    logic     mem_read;
    logic     mem_write;
    logic     branch;
    logic     branch_taken;
    logic     illegal;

    // Architectural model and expectations for the next sample
    word_t       model_regs [NREGS];
    word_t       exp_instr;
    word_t       exp_result;
    bit          exp_result_known;
    bit          exp_valid;
    bit          exp_writes;
    reg_sel_t    exp_rd;
    bit          exp_write_reg;
    bit          exp_mem_read;
    bit          exp_mem_write;
    bit          exp_branch;
    bit          exp_taken;
    bit          exp_illegal;
    int unsigned idle_count  = 0;
    int unsigned cycle_count = 0;

    tb_clkgen i_tb_clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    rv_id_ex i_rv_id_ex (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .result       (result),
        .result_valid (result_valid),
        .rd           (rd),
        .write_reg    (write_reg),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .branch       (branch),
        .branch_taken (branch_taken),
        .illegal      (illegal)
    );

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////
    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %h, expected %h (instr %h)",
                     $time, what, got, exp, exp_instr);
            $display("TEST FAILED");
            $fatal(1, "Result mismatch");
        end
    endtask

    task automatic check_sel(input string what, input reg_sel_t got, input reg_sel_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is x%0d, expected x%0d (instr %h)",
                     $time, what, got, exp, exp_instr);
            $display("TEST FAILED");
            $fatal(1, "Destination mismatch");
        end
    endtask

    task automatic check_flag(input string what, input logic got, input bit exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %0b, expected %0b (instr %h)",
                     $time, what, got, exp, exp_instr);
            $display("TEST FAILED");
            $fatal(1, "Flag mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////
    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // funct3 semantics of OP and OP-IMM, alt is funct7[5]
    function automatic word_t alu_model(input logic [2:0] f3, input bit alt,
                                        input word_t a, input word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic bit branch_model(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'b000:  return a == b;                     // BEQ
            3'b001:  return a != b;                     // BNE
            3'b100:  return $signed(a) < $signed(b);    // BLT
            3'b101:  return $signed(a) >= $signed(b);   // BGE
            3'b110:  return a < b;                      // BLTU
            default: return a >= b;                     // BGEU
        endcase
    endfunction

    // x0 one time in eight, so discarded writes show up often
    function automatic reg_sel_t pick_reg();
        if ($urandom_range(0, 7) == 0) begin
            return '0;
        end
        return reg_sel_t'($urandom_range(1, NREGS - 1));
    endfunction

    task automatic expect_none();
        exp_valid     = 1'b0;
        exp_writes    = 1'b0;
        exp_rd        = '0;
        exp_write_reg = 1'b0;
        exp_mem_read  = 1'b0;
        exp_mem_write = 1'b0;
        exp_branch    = 1'b0;
        exp_taken     = 1'b0;
        exp_illegal   = 1'b0;
    endtask

    task automatic set_write(input reg_sel_t sel, input word_t value);
        exp_writes       = 1'b1;
        exp_rd           = sel;
        exp_result       = value;
        exp_result_known = 1'b1;
        exp_write_reg    = (sel != '0);
        if (sel != '0) begin
            model_regs[sel] = value;    // Visible to the next instruction
        end
    endtask

    task automatic set_address(input word_t value);
        exp_result       = value;       // Effective address, no writeback
        exp_result_known = 1'b1;
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////
    task automatic drive_idle();
        expect_none();                  // Result holds, flags drop
        instr       = word_t'($urandom);
        instr_valid = 1'b0;
        exp_instr   = instr;
    endtask

    task automatic drive_instr();
        int unsigned pick;
        logic [2:0]  f3;
        logic [11:0] imm12;
        logic [12:0] imm13;
        logic [19:0] imm20;
        reg_sel_t    rs1_sel;
        reg_sel_t    rs2_sel;
        reg_sel_t    rd_sel;
        word_t       a;
        word_t       b;
        bit          alt;

        pick    = $urandom_range(0, 99);
        f3      = 3'($urandom_range(0, 7));
        imm12   = 12'($urandom);
        imm13   = {12'($urandom), 1'b0};
        imm20   = 20'($urandom);
        rs1_sel = pick_reg();
        rs2_sel = pick_reg();
        rd_sel  = pick_reg();
        a       = model_regs[rs1_sel];
        b       = model_regs[rs2_sel];
        alt     = ((f3 == 3'b000) || (f3 == 3'b101)) && ($urandom_range(0, 1) == 1);

        expect_none();
        exp_valid = 1'b1;
        if (pick < 30) begin
            instr = {alt ? 7'h20 : 7'h00, rs2_sel, rs1_sel, f3, rd_sel, OPC_OP};
            set_write(rd_sel, alu_model(f3, alt, a, b));
        end else if (pick < 55) begin
            if (f3 == 3'b101) begin
                imm12 = {alt ? 7'h20 : 7'h00, imm12[4:0]};     // SRLI or SRAI
            end else begin
                alt = 1'b0;     // No SUBI
                if (f3 == 3'b001) begin
                    imm12 = {7'h00, imm12[4:0]};
                end
            end
            instr = {imm12, rs1_sel, f3, rd_sel, OPC_OP_IMM};
            set_write(rd_sel, alu_model(f3, alt, a, sext12(imm12)));
        end else if (pick < 65) begin
            instr = {imm20, rd_sel, OPC_LUI};
            set_write(rd_sel, {imm20, 12'h000});
        end else if (pick < 75) begin
            instr = {imm12, rs1_sel, 3'b010, rd_sel, OPC_LOAD};
            set_address(a + sext12(imm12));
            exp_mem_read = 1'b1;
        end else if (pick < 83) begin
            instr = {imm12[11:5], rs2_sel, rs1_sel, 3'b010, imm12[4:0], OPC_STORE};
            set_address(a + sext12(imm12));
            exp_mem_write = 1'b1;
        end else if (pick < 95) begin
            if (f3[2:1] == 2'b01) begin
                f3 = f3 ^ 3'b110;       // 010 and 011 are reserved
            end
            instr = {imm13[12], imm13[10:5], rs2_sel, rs1_sel, f3,
                     imm13[4:1], imm13[11], OPC_BRANCH};
            exp_result_known = 1'b0;
            exp_branch       = 1'b1;
            exp_taken        = branch_model(f3, a, b);
        end else begin
            // AUIPC, JAL, JALR, or an opcode ending in 1011
            case (pick % 4)
                0:       instr = {imm20, rd_sel, OPC_AUIPC};
                1:       instr = {imm20, rd_sel, OPC_JAL};
                2:       instr = {imm12, rs1_sel, 3'b000, rd_sel, OPC_JALR};
                default: instr = {imm20, rd_sel, f3, 4'b1011};
            endcase
            exp_result_known = 1'b0;
            exp_illegal      = 1'b1;
        end
        instr_valid = 1'b1;
        exp_instr   = instr;
    endtask

    task automatic check_outputs();
        check_flag("result_valid", result_valid, exp_valid);
        check_flag("write_reg", write_reg, exp_write_reg);
        check_flag("mem_read", mem_read, exp_mem_read);
        check_flag("mem_write", mem_write, exp_mem_write);
        check_flag("branch", branch, exp_branch);
        check_flag("branch_taken", branch_taken, exp_taken);
        check_flag("illegal", illegal, exp_illegal);
        if (exp_result_known) begin
            check_word("result", result, exp_result);
        end
        if (exp_writes) begin
            check_sel("rd", rd, exp_rd);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence, drive and sample on the falling edge
    ////////////////////////////////////////////////////////////
    initial begin
        void'($urandom(RAND_SEED));
        instr       = '0;
        instr_valid = 1'b0;
        for (int i = 0; i < NREGS; i++) begin
            model_regs[i] = '0;
        end
        expect_none();
        exp_instr        = '0;
        exp_result       = '0;      // Reset value
        exp_result_known = 1'b1;

        wait (rst_n === 1'b1);
        @(negedge clk);
        for (int n = 0; n < NUM_INSTR; n++) begin
            while ($urandom_range(0, 4) == 0) begin     // About 20 % idle
                check_outputs();
                drive_idle();
                idle_count++;
                @(negedge clk);
            end
            check_outputs();
            drive_instr();
            @(negedge clk);
        end
        check_outputs();            // Last instruction
        $display("%0d instructions, %0d idle cycles", NUM_INSTR, idle_count);
        if (i_rv_id_ex.i_rv_id_ex_sva.fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "Timeout");
        end
    end

endmodule

`default_nettype wire

/* include/rv_opcodes.svh */
`ifndef RV_OPCODES_SVH
`define RV_OPCODES_SVH

////////////////////////////////////////////////////////////
// RV32I base opcodes, full 7 bits
////////////////////////////////////////////////////////////
`define OPC_LOAD    7'b0000011  // LB LH LW LBU LHU
`define OPC_OP_IMM  7'b0010011  // ADDI ... SRAI
`define OPC_AUIPC   7'b0010111
`define OPC_STORE   7'b0100011  // SB SH SW
`define OPC_OP      7'b0110011  // Register-register ALU ops
`define OPC_LUI     7'b0110111
`define OPC_BRANCH  7'b1100011
`define OPC_JALR    7'b1100111
`define OPC_JAL     7'b1101111

////////////////////////////////////////////////////////////
// funct3 for OP and OP-IMM
////////////////////////////////////////////////////////////
`define F3_ADD_SUB  3'b000      // funct7[5] picks SUB on OP only
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SRL_SRA  3'b101      // funct7[5] picks SRA
`define F3_OR       3'b110
`define F3_AND      3'b111

// funct3 for BRANCH
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101
`define F3_BLTU     3'b110
`define F3_BGEU     3'b111

`endif

/* src/rv_alu_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_alu_stage
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     instr_valid,

    input  word_t    rs1_data,
    input  word_t    rs2_data,
    input  word_t    immd,

    input  alu_op_t  alu_op,
    input  logic     src_immd,
    input  logic     zero_a,
    input  br_cond_t br_cond,

    input  reg_sel_t rd,
    input  logic     writes_rd,
    input  logic     mem_read,
    input  logic     mem_write,
    input  logic     branch,
    input  logic     illegal,

    output word_t    alu_result,    // Combinational, to register file
    output word_t    result,
    output logic     result_valid,
    output reg_sel_t rd_q,
    output logic     write_reg,
    output logic     mem_read_q,
    output logic     mem_write_q,
    output logic     branch_q,
    output logic     branch_taken,
    output logic     illegal_q
);

    word_t op_a;
    word_t op_b;
    logic  taken;

    assign op_a = zero_a ? '0 : rs1_data;       // LUI
    assign op_b = src_immd ? immd : rs2_data;

    ////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_result = op_a + op_b;
            ALU_SUB:  alu_result = op_a - op_b;
            ALU_SLL:  alu_result = op_a << op_b[4:0];
            ALU_SLT:  alu_result = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU: alu_result = word_t'(op_a < op_b);
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_SRL:  alu_result = op_a >> op_b[4:0];
            ALU_SRA:  alu_result = $signed(op_a) >>> op_b[4:0];  // Sign fill
            ALU_OR:   alu_result = op_a | op_b;
            ALU_AND:  alu_result = op_a & op_b;
            default:  alu_result = '0;
        endcase
    end

    // Branch compare on the raw register values
    always_comb begin
        case (br_cond)
            BR_EQ:   taken = (rs1_data == rs2_data);
            BR_NE:   taken = (rs1_data != rs2_data);
            BR_LT:   taken = ($signed(rs1_data) < $signed(rs2_data));
            BR_GE:   taken = ($signed(rs1_data) >= $signed(rs2_data));
            BR_LTU:  taken = (rs1_data < rs2_data);
            BR_GEU:  taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;      // funct3 010/011 undefined
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Output register, one cycle after issue
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result       <= '0;
            rd_q         <= '0;
            result_valid <= 1'b0;
            write_reg    <= 1'b0;
            mem_read_q   <= 1'b0;
            mem_write_q  <= 1'b0;
            branch_q     <= 1'b0;
            branch_taken <= 1'b0;
            illegal_q    <= 1'b0;
        end else begin
            // Flags drop on idle cycles
            result_valid <= instr_valid;
            write_reg    <= instr_valid && writes_rd && (rd != '0);
            mem_read_q   <= instr_valid && mem_read;
            mem_write_q  <= instr_valid && mem_write;
            branch_q     <= instr_valid && branch;
            branch_taken <= instr_valid && branch && taken;
            illegal_q    <= instr_valid && illegal;
            if (instr_valid) begin
                result <= alu_result;   // Held while idle
                rd_q   <= rd;
            end
        end
    end

endmodule

`default_nettype wire

/* src/rv_decode_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_decode_ctrl
    import rv_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  word_t      instr,
    input  logic       instr_valid,

    output reg_sel_t   rs1,
    output reg_sel_t   rs2,
    output reg_sel_t   rd,
    output instr_fmt_t fmt,
    output alu_op_t    alu_op,
    output logic       src_immd,    // Operand B from immediate
    output logic       zero_a,      // Operand A forced to zero (LUI)
    output logic       reg_we,      // Register file write this edge
    output logic       writes_rd,
    output logic       mem_read,
    output logic       mem_write,
    output logic       branch,
    output logic       illegal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt_ok;     // funct3 has a funct7[5] variant on OP

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign alt_ok = (funct3 == `F3_ADD_SUB) || (funct3 == `F3_SRL_SRA);

    ////////////////////////////////////////////////////////////
    // Opcode decode
    ////////////////////////////////////////////////////////////
    always_comb begin
        rs1       = '0;
        rs2       = '0;
        rd        = '0;
        fmt       = FMT_NOP;
        alu_op    = ALU_ADD;
        zero_a    = 1'b0;
        writes_rd = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        branch    = 1'b0;
        illegal   = 1'b0;

        case (opcode)
            `OPC_OP: begin
                fmt       = FMT_R;
                rd        = instr[11:7];
                rs1       = instr[19:15];
                rs2       = instr[24:20];
                writes_rd = 1'b1;
                alu_op    = alu_op_t'({instr[30] && alt_ok, funct3}); // SUB/SRA only
            end
            `OPC_OP_IMM: begin
                fmt       = FMT_I;
                rd        = instr[11:7];
                rs1       = instr[19:15];
                writes_rd = 1'b1;
                // No SUBI, so instr[30] only matters for SRAI
                alu_op    = alu_op_t'({instr[30] && (funct3 == `F3_SRL_SRA), funct3});
            end
            `OPC_LOAD: begin
                fmt      = FMT_I;
                rs1      = instr[19:15];
                mem_read = 1'b1;        // Address only, nothing written back
            end
            `OPC_STORE: begin
                fmt       = FMT_S;
                rs1       = instr[19:15];
                rs2       = instr[24:20]; // Store data source
                mem_write = 1'b1;
            end
            `OPC_BRANCH: begin
                fmt    = FMT_B;
                rs1    = instr[19:15];
                rs2    = instr[24:20];
                alu_op = ALU_SUB;       // Compare done in the ALU stage
                branch = 1'b1;
            end
            `OPC_LUI: begin
                fmt       = FMT_U;
                rd        = instr[11:7];
                zero_a    = 1'b1;       // 0 + imm
                writes_rd = 1'b1;
            end
            // No PC in this slice
            `OPC_AUIPC: begin
                fmt     = FMT_U;
                illegal = 1'b1;
            end
            `OPC_JAL: begin
                fmt     = FMT_J;
                illegal = 1'b1;
            end
            `OPC_JALR: begin
                fmt     = FMT_I;
                illegal = 1'b1;
            end
            default: illegal = 1'b1;    // Unknown opcode
        endcase
    end

    // Immediate used by I, S and U formats
    assign src_immd = (fmt == FMT_I) || (fmt == FMT_S) || (fmt == FMT_U);

    // Idle cycles and x0 never write
    assign reg_we = instr_valid && writes_rd && (rd != '0);

endmodule

`default_nettype wire

/* src/rv_id_ex.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_id_ex
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  word_t    instr,
    input  logic     instr_valid,

    output word_t    result,
    output logic     result_valid,
    output reg_sel_t rd,
    output logic     write_reg,
    output logic     mem_read,
    output logic     mem_write,
    output logic     branch,
    output logic     branch_taken,
    output logic     illegal
);

    // Decoder outputs
    reg_sel_t   rs1;
    reg_sel_t   rs2;
    reg_sel_t   dec_rd;
    instr_fmt_t fmt;
    alu_op_t    alu_op;
    logic       src_immd;
    logic       zero_a;
    logic       reg_we;
    logic       writes_rd;
    logic       dec_mem_read;
    logic       dec_mem_write;
    logic       dec_branch;
    logic       dec_illegal;

    // Datapath
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      immd;
    word_t      alu_result;     // Writeback data, same edge
    br_cond_t   br_cond;

    assign br_cond = br_cond_t'(instr[14:12]);  // Branch funct3

    ////////////////////////////////////////////////////////////
    // Instances
    ////////////////////////////////////////////////////////////
    rv_decode_ctrl i_rv_decode_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (dec_rd),
        .fmt         (fmt),
        .alu_op      (alu_op),
        .src_immd    (src_immd),
        .zero_a      (zero_a),
        .reg_we      (reg_we),
        .writes_rd   (writes_rd),
        .mem_read    (dec_mem_read),
        .mem_write   (dec_mem_write),
        .branch      (dec_branch),
        .illegal     (dec_illegal)
    );

    rv_regfile i_rv_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (reg_we),
        .wsel     (dec_rd),
        .wdata    (alu_result)
    );

    rv_imm_gen i_rv_imm_gen (
        .instr (instr),
        .fmt   (fmt),
        .immd  (immd)
    );

    rv_alu_stage i_rv_alu_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .immd         (immd),
        .alu_op       (alu_op),
        .src_immd     (src_immd),
        .zero_a       (zero_a),
        .br_cond      (br_cond),
        .rd           (dec_rd),
        .writes_rd    (writes_rd),
        .mem_read     (dec_mem_read),
        .mem_write    (dec_mem_write),
        .branch       (dec_branch),
        .illegal      (dec_illegal),
        .alu_result   (alu_result),
        .result       (result),
        .result_valid (result_valid),
        .rd_q         (rd),
        .write_reg    (write_reg),
        .mem_read_q   (mem_read),
        .mem_write_q  (mem_write),
        .branch_q     (branch),
        .branch_taken (branch_taken),
        .illegal_q    (illegal)
    );

endmodule

`default_nettype wire

/* src/rv_imm_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_imm_gen
    import rv_pkg::*;
(
    input  word_t      instr,
    input  instr_fmt_t fmt,
    output word_t      immd
);

    logic sign;

    assign sign = instr[31];    // Immediate sign is always bit 31

    ////////////////////////////////////////////////////////////
    // Immediate assembly per format
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (fmt)
            FMT_I: begin
                immd = {{20{sign}}, instr[31:20]};
            end
            FMT_S: begin
                immd = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            FMT_B: begin
                // Halfword offset, bit 0 implied
                immd = {{19{sign}}, instr[31], instr[7], instr[30:25],
                        instr[11:8], 1'b0};
            end
            FMT_U: begin
                immd = {instr[31:12], 12'h000};     // Upper 20, low bits zero
            end
            FMT_J: begin
                immd = {{11{sign}}, instr[31], instr[19:12], instr[20],
                        instr[30:21], 1'b0};
            end
            default: begin
                immd = '0;      // R-type and NOP carry none
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    `include "rv_opcodes.svh"

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////
    localparam int XLEN      = 32;  // Data and instruction width
    localparam int NREGS     = 32;  // x0 .. x31
    localparam int REG_SEL_W = 5;   // log2(NREGS)

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [REG_SEL_W-1:0] reg_sel_t;

    ////////////////////////////////////////////////////////////
    // ALU operation, encoded as {funct7[5], funct3}
    ////////////////////////////////////////////////////////////
    typedef enum logic [3:0] {
        ALU_ADD  = {1'b0, `F3_ADD_SUB},
        ALU_SUB  = {1'b1, `F3_ADD_SUB},
        ALU_SLL  = {1'b0, `F3_SLL},
        ALU_SLT  = {1'b0, `F3_SLT},
        ALU_SLTU = {1'b0, `F3_SLTU},
        ALU_XOR  = {1'b0, `F3_XOR},
        ALU_SRL  = {1'b0, `F3_SRL_SRA},
        ALU_SRA  = {1'b1, `F3_SRL_SRA},
        ALU_OR   = {1'b0, `F3_OR},
        ALU_AND  = {1'b0, `F3_AND}
    } alu_op_t;

    // Immediate layout selector
    typedef enum logic [2:0] {
        FMT_NOP,
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J
    } instr_fmt_t;

    // Branch condition, same as branch funct3
    typedef enum logic [2:0] {
        BR_EQ  = `F3_BEQ,
        BR_NE  = `F3_BNE,
        BR_LT  = `F3_BLT,
        BR_GE  = `F3_BGE,
        BR_LTU = `F3_BLTU,
        BR_GEU = `F3_BGEU
    } br_cond_t;

    // Decoder issue tracking
    typedef enum logic {
        DEC_IDLE,
        DEC_ISSUED      // Result pending in the ALU stage
    } dec_state_t;

endpackage

`default_nettype wire

/* src/rv_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_regfile
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    input  reg_sel_t rs1,
    input  reg_sel_t rs2,
    output word_t    rs1_data,
    output word_t    rs2_data,

    input  logic     we,
    input  reg_sel_t wsel,
    input  word_t    wdata
);

    word_t regs [NREGS];

    ////////////////////////////////////////////////////////////
    // Write port
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wsel != '0)) begin  // x0 stays zero
            regs[wsel] <= wdata;
        end
    end

    // Read ports
    // Combinational, so the next instruction sees this edge's write
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire
